//--- Bender.yml
package:
  name: dcachemem

sources:
  # design, in compile order
  - rtl/dcache_cfg_pkg.sv
  - rtl/dcache_types_pkg.sv
  - rtl/evict_if.sv
  - rtl/dcache_set.sv
  - rtl/dcache_victim.sv
  - rtl/dcachemem.sv

  - target: test
    files:
      - tests/dcachemem_assert.sv
      - tests/dcachemem_tb.sv

//--- build.f
rtl/dcache_cfg_pkg.sv
rtl/dcache_types_pkg.sv
rtl/evict_if.sv
rtl/dcache_set.sv
rtl/dcache_victim.sv
rtl/dcachemem.sv
tests/dcachemem_assert.sv
tests/dcachemem_tb.sv

//--- rtl/dcache_cfg_pkg.sv
/*
 * Geometry of the data cache storage: set count, tag and line widths,
 * and the victim buffer depth. Imported by the type package and the RTL.
 */
package dcache_cfg_pkg;

	//////////////////////////////////////////////////////////////////////
	// set array
	//////////////////////////////////////////////////////////////////////

	localparam int DCACHE_IDX_BITS  = 3;                    // 8 sets
	localparam int DCACHE_TAG_BITS  = 8;                    // small, so lines collide often
	localparam int DCACHE_SETS      = 1 << DCACHE_IDX_BITS;
	localparam int DCACHE_DATA_BITS = 64;                   // one line

	//////////////////////////////////////////////////////////////////////
	// victim buffer
	//////////////////////////////////////////////////////////////////////

	localparam int VICTIM_ENTRIES   = 2;                    // one lru bit covers two slots

endpackage

//--- rtl/dcache_set.sv
`timescale 1ns/100ps
/*
 * One two-way set with a single LRU bit. Lookup is combinational, a write
 * lands at the next edge and shows the line it displaces on evict_*.
 */
module dcache_set
	import dcache_types_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  mem_op_e op,
	input  tag_t    wr_tag,
	input  line_t   wr_data,
	input  tag_t    rd_tag,
	output line_t   rd_data,
	output logic    rd_hit,
	output logic    evict_valid,
	output tag_t    evict_tag,
	output line_t   evict_data
);

	tag_t       tags [2];
	line_t      data [2];
	logic [1:0] valids;
	logic       lru;      // way to replace next
	logic [1:0] rd_match;
	logic [1:0] wr_match;
	logic       hit_way;
	logic       wr_way;

	//////////////////////////////////////////////////////////////////////
	// tag compare
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			rd_match[w] = valids[w] && (tags[w] == rd_tag);
			wr_match[w] = valids[w] && (tags[w] == wr_tag);
		end
	end

	assign hit_way = rd_match[1];
	assign rd_hit  = |rd_match;   // independent of op, the top decides
	assign rd_data = data[hit_way];

	// matching way, else free way, else lru way
	always_comb begin
		if (wr_match[0])
			wr_way = 1'b0;
		else if (wr_match[1])
			wr_way = 1'b1;
		else if (!valids[0])
			wr_way = 1'b0;
		else if (!valids[1])
			wr_way = 1'b1;
		else
			wr_way = lru;
	end

	// only a full set without a tag match can displace a line
	assign evict_valid = (op == op_write) && valids[wr_way] && !wr_match[wr_way];
	assign evict_tag   = tags[wr_way];
	assign evict_data  = data[wr_way];

	//////////////////////////////////////////////////////////////////////
	// state update
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			valids <= '0;
			lru    <= 1'b0;
		end else begin
			case (op)
				op_write: begin
					valids[wr_way] <= 1'b1;
					lru            <= ~wr_way; // written way is most recent
				end
				op_lookup: begin
					if (rd_hit)
						lru <= ~hit_way;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (op == op_write) begin
			tags[wr_way] <= wr_tag;
			data[wr_way] <= wr_data;
		end
	end

endmodule

//--- rtl/dcache_types_pkg.sv
/*
 * Port types of the data cache: the per-array operation and the
 * index, tag and line vectors sized from the cache geometry.
 */
package dcache_types_pkg;

	import dcache_cfg_pkg::*;

	// operation on one set or on the victim buffer
	typedef enum logic [1:0] {
		op_idle,
		op_lookup,
		op_write
	} mem_op_e;

	// address split of a line
	typedef logic [DCACHE_IDX_BITS-1:0]  idx_t;
	typedef logic [DCACHE_TAG_BITS-1:0]  tag_t;

	// line payload
	typedef logic [DCACHE_DATA_BITS-1:0] line_t;

endpackage

//--- rtl/dcache_victim.sv
`timescale 1ns/100ps
/*
 * Two-entry fully associative victim buffer. Lookup matches index and tag
 * in the same cycle, a hit or a core write frees the entry at the edge.
 */
module dcache_victim
	import dcache_cfg_pkg::*;
	import dcache_types_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  mem_op_e op,
	input  tag_t    tag,
	input  idx_t    idx,
	output line_t   rd_data,
	output logic    rd_hit,
	evict_if.sink   push
);

	idx_t                      ent_idx  [VICTIM_ENTRIES];
	tag_t                      ent_tag  [VICTIM_ENTRIES];
	line_t                     ent_data [VICTIM_ENTRIES];
	logic [VICTIM_ENTRIES-1:0] ent_valid;
	logic [VICTIM_ENTRIES-1:0] next_valid;
	logic [VICTIM_ENTRIES-1:0] match;
	logic [VICTIM_ENTRIES-1:0] drop;
	logic                      lru;       // oldest push
	logic                      hit_slot;
	logic                      push_slot;

	//////////////////////////////////////////////////////////////////////
	// lookup
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int s = 0; s < VICTIM_ENTRIES; s++) begin
			match[s] = ent_valid[s] && (ent_idx[s] == idx) && (ent_tag[s] == tag);
		end
	end

	assign hit_slot = match[1];
	assign rd_hit   = (op == op_lookup) && (|match);
	assign rd_data  = ent_data[hit_slot];

	// a lookup hit moves the line out, a write makes it stale
	assign drop = (op != op_idle) ? match : '0;

	//////////////////////////////////////////////////////////////////////
	// push placement
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (|drop)
			push_slot = drop[1];   // reuse the slot freed now
		else if (!ent_valid[0])
			push_slot = 1'b0;
		else if (!ent_valid[1])
			push_slot = 1'b1;
		else
			push_slot = lru;
	end

	always_comb begin
		next_valid = ent_valid & ~drop;
		if (push.valid)
			next_valid[push_slot] = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ent_valid <= '0;
			lru       <= 1'b0;
		end else begin
			ent_valid <= next_valid;
			if (push.valid)
				lru <= ~push_slot; // only a push ages the entries
		end
	end

	always_ff @(posedge clock) begin
		if (push.valid) begin
			ent_idx[push_slot]  <= push.idx;
			ent_tag[push_slot]  <= push.tag;
			ent_data[push_slot] <= push.data;
		end
	end

endmodule

//--- rtl/dcachemem.sv
`timescale 1ns/100ps
/*
 * Data cache storage: eight two-way sets backed by a victim buffer.
 * Reads answer in the same cycle, all state changes land at the next edge.
 */
module dcachemem
	import dcache_cfg_pkg::*;
	import dcache_types_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  en,
	input  logic  wr_en,
	input  tag_t  wr_tag,
	input  idx_t  wr_idx,
	input  line_t wr_data,
	input  tag_t  rd_tag,
	input  idx_t  rd_idx,
	output line_t rd_data,
	output logic  rd_valid
);

	mem_op_e                set_op [DCACHE_SETS];
	mem_op_e                acc_op;           // op of the one set accessed
	mem_op_e                victim_op;
	idx_t                   acc_idx;
	tag_t                   acc_tag;
	logic                   swap;             // victim hit moving back into its set
	line_t                  set_wr_data;
	line_t                  set_rd_data [DCACHE_SETS];
	logic [DCACHE_SETS-1:0] set_rd_hit;
	logic [DCACHE_SETS-1:0] set_evict_valid;
	tag_t                   set_evict_tag [DCACHE_SETS];
	line_t                  set_evict_data [DCACHE_SETS];
	logic                   set_hit;
	line_t                  victim_rd_data;
	logic                   victim_rd_hit;

	evict_if evict ();

	//////////////////////////////////////////////////////////////////////
	// operation steering
	//////////////////////////////////////////////////////////////////////

	assign acc_idx = wr_en ? wr_idx : rd_idx;
	assign acc_tag = wr_en ? wr_tag : rd_tag; // also the tag of a swap write
	assign set_hit = set_rd_hit[rd_idx];

	assign victim_op = !en ? op_idle : (wr_en ? op_write : op_lookup);

	// set is checked before the victim buffer
	always_comb begin
		acc_op = op_idle;
		swap   = 1'b0;
		if (en) begin
			if (wr_en) begin
				acc_op = op_write;
			end else if (!set_hit && victim_rd_hit) begin
				acc_op = op_write;
				swap   = 1'b1;
			end else begin
				acc_op = op_lookup;
			end
		end
	end

	assign set_wr_data = swap ? victim_rd_data : wr_data;

	//////////////////////////////////////////////////////////////////////
	// set array
	//////////////////////////////////////////////////////////////////////

	for (genvar s = 0; s < DCACHE_SETS; s++) begin : g_set
		assign set_op[s] = (acc_idx == idx_t'(s)) ? acc_op : op_idle;

		dcache_set set_i (
			.clock       (clock),
			.reset       (reset),
			.op          (set_op[s]),
			.wr_tag      (acc_tag),
			.wr_data     (set_wr_data),
			.rd_tag      (rd_tag),
			.rd_data     (set_rd_data[s]),
			.rd_hit      (set_rd_hit[s]),
			.evict_valid (set_evict_valid[s]),
			.evict_tag   (set_evict_tag[s]),
			.evict_data  (set_evict_data[s])
		);
	end

	// one set access per cycle, so at most one line leaves
	assign evict.valid = set_evict_valid[acc_idx];
	assign evict.tag   = set_evict_tag[acc_idx];
	assign evict.idx   = acc_idx;
	assign evict.data  = set_evict_data[acc_idx];

	//////////////////////////////////////////////////////////////////////
	// victim buffer
	//////////////////////////////////////////////////////////////////////

	dcache_victim victim_i (
		.clock   (clock),
		.reset   (reset),
		.op      (victim_op),
		.tag     (acc_tag),
		.idx     (acc_idx),
		.rd_data (victim_rd_data),
		.rd_hit  (victim_rd_hit),
		.push    (evict)
	);

	//////////////////////////////////////////////////////////////////////
	// read result
	//////////////////////////////////////////////////////////////////////

	assign rd_valid = en && !wr_en && (set_hit || victim_rd_hit);
	assign rd_data  = set_hit ? set_rd_data[rd_idx] : victim_rd_data;

endmodule

//--- rtl/evict_if.sv
`timescale 1ns/100ps
/*
 * One evicted line on its way from the set array to the victim buffer.
 * valid pulses for one cycle and the buffer takes the line at that edge.
 */
interface evict_if
	import dcache_types_pkg::*;
();

	logic  valid; // displaced line, taken at the edge
	tag_t  tag;
	idx_t  idx;   // set it came from
	line_t data;

	modport source (
		output valid,
		output tag,
		output idx,
		output data
	);

	modport sink (
		input valid,
		input tag,
		input idx,
		input data
	);

endinterface

//--- tests/dcachemem_assert.sv
`timescale 1ns/100ps
/*
 * Concurrent checks on the cache top, bound into every dcachemem instance.
 * fail_count lets the testbench see assertion failures at the end of the run.
 */
module dcachemem_assert
	import dcache_cfg_pkg::*;
	import dcache_types_pkg::*;
(
	input logic    clock,
	input logic    reset,
	input logic    en,
	input logic    wr_en,
	input logic    rd_valid,
	input logic    evict_valid,
	input mem_op_e set_op [DCACHE_SETS]
);

	int   fail_count = 0;
	int   busy_sets;
	logic any_write;

	always_comb begin
		busy_sets = 0;
		any_write = 1'b0;
		for (int s = 0; s < DCACHE_SETS; s++) begin
			if (set_op[s] != op_idle)
				busy_sets++;
			if (set_op[s] == op_write)
				any_write = 1'b1;
		end
	end

	// one set per enabled cycle, none while idle
	one_set_access: assert property (@(posedge clock) disable iff (reset)
		busy_sets == (en ? 1 : 0))
		else begin
			$error("set access count does not match en");
			fail_count++;
		end

	// a read cycle only evicts when it swaps back a victim hit
	evict_from_write: assert property (@(posedge clock) disable iff (reset)
		evict_valid |-> (any_write && (wr_en || rd_valid)))
		else begin
			$error("eviction outside a core write or a swap");
			fail_count++;
		end

	read_only_on_read: assert property (@(posedge clock) disable iff (reset)
		rd_valid |-> (en && !wr_en))
		else begin
			$error("rd_valid outside a read cycle");
			fail_count++;
		end

	// valids are clear one edge after reset
	empty_after_reset: assert property (@(posedge clock)
		reset |=> !rd_valid)
		else begin
			$error("rd_valid high right after reset");
			fail_count++;
		end

endmodule

bind dcachemem dcachemem_assert assert_i (
	.clock       (clock),
	.reset       (reset),
	.en          (en),
	.wr_en       (wr_en),
	.rd_valid    (rd_valid),
	.evict_valid (evict.valid),
	.set_op      (set_op)
);

//--- tests/dcachemem_tb.sv
`timescale 1ns/100ps
/*
 * Random traffic into the cache storage, compared each cycle against a
 * model of the sets and the victim buffer kept here.
 */
module dcachemem_tb
	import dcache_cfg_pkg::*;
	import dcache_types_pkg::*;
();

	localparam int CYCLES        = 3000;
	localparam int RESET_CYCLES  = 10;
	localparam int RESET_TIMEOUT = 20;

	logic   clock;
	logic   reset;
	logic   en;
	logic   wr_en;
	tag_t   wr_tag;
	idx_t   wr_idx;
	line_t  wr_data;
	tag_t   rd_tag;
	idx_t   rd_idx;
	line_t  rd_data;
	logic   rd_valid;
	integer seed;

	// model of the storage
	tag_t   m_tag   [DCACHE_SETS][2];
	line_t  m_data  [DCACHE_SETS][2];
	logic   m_valid [DCACHE_SETS][2];
	logic   m_lru   [DCACHE_SETS];     // way to replace next
	idx_t   v_idx   [VICTIM_ENTRIES];
	tag_t   v_tag   [VICTIM_ENTRIES];
	line_t  v_data  [VICTIM_ENTRIES];
	logic   v_valid [VICTIM_ENTRIES];
	logic   v_lru;

	int     n_set_hit;
	int     n_victim_hit;
	int     n_evict;

	dcachemem dut_i (.*);

	always #2 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// checking
	//////////////////////////////////////////////////////////////////////

	task automatic check(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic int set_find(input idx_t i, input tag_t t);
		for (int w = 0; w < 2; w++)
			if (m_valid[i][w] && m_tag[i][w] == t)
				return w;
		return -1;
	endfunction

	function automatic int victim_find(input idx_t i, input tag_t t);
		for (int s = 0; s < VICTIM_ENTRIES; s++)
			if (v_valid[s] && v_idx[s] == i && v_tag[s] == t)
				return s;
		return -1;
	endfunction

	task automatic set_write(input idx_t i, input tag_t t, input line_t d,
			output logic ev, output tag_t ev_tag, output line_t ev_data);
		int way;
		way = set_find(i, t);
		if (way < 0) begin
			if (!m_valid[i][0])
				way = 0;
			else if (!m_valid[i][1])
				way = 1;
			else
				way = m_lru[i];
		end
		ev            = m_valid[i][way] && (m_tag[i][way] != t);
		ev_tag        = m_tag[i][way];
		ev_data       = m_data[i][way];
		m_tag[i][way]   = t;
		m_data[i][way]  = d;
		m_valid[i][way] = 1'b1;
		m_lru[i]        = (way == 0);
	endtask

	task automatic victim_push(input int freed, input idx_t i, input tag_t t,
			input line_t d);
		int slot;
		if (freed >= 0)
			slot = freed;          // slot emptied this cycle
		else if (!v_valid[0])
			slot = 0;
		else if (!v_valid[1])
			slot = 1;
		else
			slot = v_lru;
		v_idx[slot]   = i;
		v_tag[slot]   = t;
		v_data[slot]  = d;
		v_valid[slot] = 1'b1;
		v_lru         = (slot == 0);
		n_evict++;
	endtask

	task automatic predict_read(output logic exp_valid, output line_t exp_data);
		int way;
		int slot;
		way       = set_find(rd_idx, rd_tag);
		slot      = victim_find(rd_idx, rd_tag);
		exp_valid = en && !wr_en && (way >= 0 || slot >= 0);
		exp_data  = (way >= 0) ? m_data[rd_idx][way] : v_data[slot >= 0 ? slot : 0];
	endtask

	// state as it will be after the coming edge
	task automatic advance_model();
		int    way;
		int    slot;
		logic  ev;
		tag_t  ev_tag;
		line_t ev_data;
		if (en && wr_en) begin
			slot = victim_find(wr_idx, wr_tag);
			if (slot >= 0)
				v_valid[slot] = 1'b0;  // stale copy
			set_write(wr_idx, wr_tag, wr_data, ev, ev_tag, ev_data);
			if (ev)
				victim_push(slot, wr_idx, ev_tag, ev_data);
		end else if (en) begin
			way  = set_find(rd_idx, rd_tag);
			slot = victim_find(rd_idx, rd_tag);
			if (slot >= 0)
				v_valid[slot] = 1'b0;
			if (way >= 0) begin
				m_lru[rd_idx] = (way == 0);
				n_set_hit++;
			end else if (slot >= 0) begin
				set_write(rd_idx, rd_tag, v_data[slot], ev, ev_tag, ev_data); // swap
				if (ev)
					victim_push(slot, rd_idx, ev_tag, ev_data);
				n_victim_hit++;
			end
		end
	endtask

	task automatic clear_model();
		for (int s = 0; s < DCACHE_SETS; s++) begin
			m_valid[s][0] = 1'b0;
			m_valid[s][1] = 1'b0;
			m_lru[s]      = 1'b0;
		end
		for (int s = 0; s < VICTIM_ENTRIES; s++)
			v_valid[s] = 1'b0;
		v_lru = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	// sets 0 and 1 get half the traffic
	function automatic idx_t pick_idx();
		logic [31:0] r;
		r = $random(seed);
		return r[3] ? r[2:0] : {2'b00, r[0]};
	endfunction

	function automatic tag_t pick_tag();
		logic [31:0] r;
		r = $random(seed);
		return tag_t'(8'h40 + r[1:0]); // four tags only
	endfunction

	task automatic drive_random();
		logic [31:0] r;
		r       = $random(seed);
		en      = (r[2:0] != 3'd0);
		wr_en   = (r[5:3] < 3'd3);
		wr_idx  = pick_idx();
		wr_tag  = pick_tag();
		wr_data = {$random(seed), $random(seed)};
		rd_idx  = pick_idx();
		rd_tag  = pick_tag();
	endtask

	initial begin
		logic  exp_valid;
		line_t exp_data;
		int    waited;
		logic  ok;
		seed    = 32'h504f_9a28;
		clock   = 1'b0;
		reset   = 1'b1;
		en      = 1'b0;
		wr_en   = 1'b0;
		wr_tag  = '0;
		wr_idx  = '0;
		wr_data = '0;
		rd_tag  = '0;
		rd_idx  = '0;
		n_set_hit    = 0;
		n_victim_hit = 0;
		n_evict      = 0;
		clear_model();

		repeat (RESET_CYCLES) @(posedge clock);
		#0.5;
		reset  = 1'b0;
		en     = 1'b1;
		rd_idx = pick_idx();
		rd_tag = pick_tag();
		waited = 0;
		#1;
		while (rd_valid !== 1'b0) begin
			if (waited >= RESET_TIMEOUT) begin
				$display("rd_valid did not go low after reset");
				$display("TEST RESULT: FAIL");
				$fatal(1, "reset timeout");
			end
			@(posedge clock);
			#1.5;
			waited++;
		end

		for (int c = 0; c < CYCLES; c++) begin
			@(posedge clock);
			#0.5;
			drive_random();
			#3;                      // just before the edge
			predict_read(exp_valid, exp_data);
			check("rd_valid", 64'(exp_valid), 64'(rd_valid));
			if (exp_valid)
				check("rd_data", exp_data, rd_data);
			advance_model();
		end

		ok = 1'b1;
		if (n_set_hit == 0 || n_victim_hit == 0 || n_evict == 0) begin
			$display("traffic missed a case: %0d set hits, %0d victim hits, %0d evictions",
				n_set_hit, n_victim_hit, n_evict);
			ok = 1'b0;
		end
		if (dut_i.assert_i.fail_count != 0) begin
			$display("%0d assertion failures during the run", dut_i.assert_i.fail_count);
			ok = 1'b0;
		end
		if (ok) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("TEST RESULT: FAIL");
			$fatal(1, "run ended with errors");
		end
	end

endmodule
